/* build.f */
+incdir+.
sys_bus_if.sv
idly_if.sv
hk_pkg.sv
adc_capture.sv
hk_regs.sv
rp_top.sv
tb_rp_top.sv

/* run_sim.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tb_rp_top \
  && ./obj_dir/Vtb_rp_top | tee /dev/stderr | grep -q "Simulation passed" \
  && echo "run ok" \
  || { echo "run not ok"; exit 1; }

/* tb_rp_top.sv */
// testbench for the rp_top top level
// clock and reset, LFSR stimulus, bus read/write tasks
// ADC reference model and assertions

`timescale 1ns/100ps

`include "hk_consts.svh"

module tb_rp_top;

  localparam int          timeout_cyc = 40;            // cycles per wait
  localparam logic [31:0] lfsr_poly   = 32'h8020_0003;

  logic                          adc_clk2d;
  logic                          reset_i;
  logic [`HK_LANES-1:0]          adc_lanes_a_i;
  logic [`HK_LANES-1:0]          adc_lanes_b_i;
  logic [`HK_BUS_AW-1:0]         sys_addr_i;
  logic [`HK_BUS_DW-1:0]         sys_wdata_i;
  logic                          sys_wen_i;
  logic                          sys_ren_i;
  logic [`HK_BUS_DW-1:0]         sys_rdata_o;
  logic                          sys_ack_o;
  logic                          sys_err_o;
  logic [`HK_EXP_W-1:0]          exp_p_dat_i;
  logic [`HK_EXP_W-1:0]          exp_n_dat_i;
  logic [`HK_EXP_W-1:0]          exp_p_dat_o;
  logic [`HK_EXP_W-1:0]          exp_n_dat_o;
  logic [`HK_EXP_W-1:0]          exp_p_dir_o;
  logic [`HK_EXP_W-1:0]          exp_n_dir_o;
  logic [`HK_LED_W-1:0]          led_o;
  logic [`HK_ADC_W-1:0]          adc_dat_a_o;
  logic [`HK_ADC_W-1:0]          adc_dat_b_o;
  logic                          adc_valid_o;

  logic [31:0]                   lfsr_q;       // galois state
  logic [3:0][`HK_LANES-1:0]     hist_a;       // [0] newest edge
  logic [3:0][`HK_LANES-1:0]     hist_b;
  logic                          adc_chk_en;
  logic                          delay_a;      // tap in upper half
  logic                          delay_b;
  logic [`HK_ADC_W-1:0]          ref_a;
  logic [`HK_ADC_W-1:0]          ref_b;
  logic [`HK_ADC_W-1:0]          last_a;       // ports at last valid
  logic [`HK_ADC_W-1:0]          last_b;
  int                            adc_checks;
  logic [31:0]                   rd_data;
  logic                          rd_err;
  logic [31:0]                   wr_val [5];
  logic [`HK_BUS_AW-1:0]         rw_addr [5];
  logic [31:0]                   mask;
  logic [31:0]                   pins;

  rp_top u_rp_top (.*);

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val[i] = lfsr_q[0];                        // one step per bit
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? lfsr_poly : 32'h0);
    end
    return val;
  endfunction

  // lane k carries bits 2k (beat A) and 2k+1 (beat B)
  function automatic logic [`HK_ADC_W-1:0] pair_code(input logic [`HK_LANES-1:0] beat_a,
                                                     input logic [`HK_LANES-1:0] beat_b);
    logic [`HK_ADC_W-1:0] code;
    for (int k = 0; k < `HK_LANES; k++)
    begin
      code[2*k]   = beat_a[k];
      code[2*k+1] = beat_b[k];
    end
    return code;
  endfunction

  function automatic logic [`HK_ADC_W-1:0] to_twos(input logic [`HK_ADC_W-1:0] code);
    return code ^ {1'b0, {(`HK_ADC_W-1){1'b1}}};   // msb kept and the rest flipped
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else fail_run($sformatf("ERROR: %s = %h, expected %h", name, got, exp));
  endtask

  task automatic next_cycle();
    logic [31:0] rnd;
    @(posedge adc_clk2d);
    #10;
    rnd = next_bits(2 * `HK_LANES);
    adc_lanes_a_i = rnd[`HK_LANES-1:0];          // fresh lanes every beat
    adc_lanes_b_i = rnd[2*`HK_LANES-1:`HK_LANES];
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    while (!sys_ack_o)
    begin
      if (n == timeout_cyc)
        fail_run("bus ack never arrived");
      next_cycle();
      n++;
    end
  endtask

  task automatic bus_write(input logic [`HK_BUS_AW-1:0] addr, input logic [31:0] data);
    sys_addr_i  = addr;
    sys_wdata_i = data;
    sys_wen_i   = 1'b1;                          // one cycle pulse
    next_cycle();
    sys_wen_i   = 1'b0;
    wait_ack();
    check_eq("sys_err_o", 32'(sys_err_o), 32'h0);
  endtask

  task automatic bus_read(input logic [`HK_BUS_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    sys_addr_i = addr;
    sys_ren_i  = 1'b1;
    next_cycle();
    sys_ren_i  = 1'b0;
    wait_ack();
    data = sys_rdata_o;                          // valid with ack
    err  = sys_err_o;
  endtask

  task automatic read_check(input logic [`HK_BUS_AW-1:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    bus_read(addr, data, err);
    check_eq("sys_err_o", 32'(err), 32'h0);
    check_eq("sys_rdata_o", data, exp);
  endtask

  task automatic wait_samples(input int n);
    int seen;
    int cyc;
    seen = 0;
    cyc  = 0;
    while (seen < n)
    begin
      if (cyc == timeout_cyc * n)
        fail_run("adc_valid_o stopped pulsing");
      next_cycle();
      cyc++;
      if (adc_valid_o)
        seen++;
    end
  endtask

  //////////////////////////////////////////////////
  // ADC reference and checks
  //////////////////////////////////////////////////

  always @(posedge adc_clk2d)
  begin
    hist_a <= {hist_a[2:0], adc_lanes_a_i};      // lanes seen at each edge
    hist_b <= {hist_b[2:0], adc_lanes_b_i};
  end

  // beats from the two edges before valid or one edge older when delayed
  assign ref_a = to_twos(delay_a ? pair_code(hist_a[3], hist_a[2])
                                 : pair_code(hist_a[2], hist_a[1]));
  assign ref_b = to_twos(delay_b ? pair_code(hist_b[3], hist_b[2])
                                 : pair_code(hist_b[2], hist_b[1]));

  always @(negedge adc_clk2d)                   // mid cycle with outputs settled
  begin
    if (!reset_i && adc_valid_o)
    begin
      if (adc_chk_en)
      begin
        assert (adc_dat_a_o === ref_a)
        else fail_run($sformatf("ERROR: adc_dat_a_o = %h, expected %h", adc_dat_a_o, ref_a));
        assert (adc_dat_b_o === ref_b)
        else fail_run($sformatf("ERROR: adc_dat_b_o = %h, expected %h", adc_dat_b_o, ref_b));
        adc_checks++;
      end
      last_a = adc_dat_a_o;
      last_b = adc_dat_b_o;
    end
  end

  ack_timing: assert property (@(posedge adc_clk2d) disable iff (reset_i)
    sys_ack_o == $past(sys_wen_i || sys_ren_i))
    else fail_run("bus ack did not follow its request by exactly one cycle");

  err_with_ack: assert property (@(posedge adc_clk2d) disable iff (reset_i)
    sys_err_o |-> sys_ack_o)
    else fail_run("bus err pulsed without ack");

  valid_gap: assert property (@(posedge adc_clk2d) disable iff (reset_i)
    !(adc_valid_o && $past(adc_valid_o)))
    else fail_run("adc_valid_o stayed high for two cycles");

  valid_rate: assert property (@(posedge adc_clk2d) disable iff (reset_i)
    $past(adc_valid_o, 2) |-> adc_valid_o)
    else fail_run("adc_valid_o missed its every second cycle slot");

  //////////////////////////////////////////////////
  // clock and test sequence
  //////////////////////////////////////////////////

  initial
  begin
    adc_clk2d = 1'b0;
    forever #50 adc_clk2d = ~adc_clk2d;          // 100 ns period
  end

  initial
  begin
    lfsr_q        = 32'h383a_216e;
    reset_i       = 1'b1;
    adc_lanes_a_i = '0;
    adc_lanes_b_i = '0;
    sys_addr_i    = '0;
    sys_wdata_i   = '0;
    sys_wen_i     = 1'b0;
    sys_ren_i     = 1'b0;
    exp_p_dat_i   = '0;
    exp_n_dat_i   = '0;
    adc_chk_en    = 1'b0;
    delay_a       = 1'b0;
    delay_b       = 1'b0;
    adc_checks    = 0;
    rw_addr = '{`HK_REG_EXP_P_DIR, `HK_REG_EXP_N_DIR, `HK_REG_EXP_P_OUT,
                `HK_REG_EXP_N_OUT, `HK_REG_LED};
    repeat (8) next_cycle();
    reset_i    = 1'b0;
    adc_chk_en = 1'b1;                           // taps start at 0

    // reset values
    check_eq("led_o", 32'(led_o), 32'h0);
    check_eq("exp_p_dat_o", 32'(exp_p_dat_o), 32'h0);
    check_eq("exp_n_dat_o", 32'(exp_n_dat_o), 32'h0);
    check_eq("exp_p_dir_o", 32'(exp_p_dir_o), 32'h0);
    check_eq("exp_n_dir_o", 32'(exp_n_dir_o), 32'h0);

    // ID word and a hole in the map
    read_check(`HK_REG_ID, `HK_ID_VAL);
    bus_read(20'h08, rd_data, rd_err);
    check_eq("sys_err_o", 32'(rd_err), 32'h1);

    // register write, port check, masked readback
    for (int r = 0; r < 4; r++)
    begin
      for (int i = 0; i < 5; i++)
      begin
        wr_val[i] = next_bits(32);
        bus_write(rw_addr[i], wr_val[i]);
      end
      check_eq("exp_p_dir_o", 32'(exp_p_dir_o), wr_val[0] & 32'h1ff);
      check_eq("exp_n_dir_o", 32'(exp_n_dir_o), wr_val[1] & 32'h1ff);
      check_eq("exp_p_dat_o", 32'(exp_p_dat_o), wr_val[2] & 32'h1ff);
      check_eq("exp_n_dat_o", 32'(exp_n_dat_o), wr_val[3] & 32'h1ff);
      check_eq("led_o", 32'(led_o), wr_val[4] & 32'h0ff);
      for (int i = 0; i < 5; i++)
      begin
        mask = (i == 4) ? 32'h0ff : 32'h1ff;     // LED is 8 wide
        read_check(rw_addr[i], wr_val[i] & mask);
      end
    end

    // pin inputs held two cycles before the read
    for (int r = 0; r < 3; r++)
    begin
      pins        = next_bits(2 * `HK_EXP_W);
      exp_p_dat_i = pins[`HK_EXP_W-1:0];
      exp_n_dat_i = pins[2*`HK_EXP_W-1:`HK_EXP_W];
      next_cycle();
      next_cycle();
      read_check(`HK_REG_EXP_P_IN, 32'(exp_p_dat_i));
      read_check(`HK_REG_EXP_N_IN, 32'(exp_n_dat_i));
    end

    wait_samples(10);

    // clear both taps then A up 17 and B down 1 so B wraps to 31
    adc_chk_en = 1'b0;
    bus_write(`HK_REG_IDLY, 32'h0000_0101);
    repeat (17) bus_write(`HK_REG_IDLY, 32'h0000_0006);
    bus_write(`HK_REG_IDLY, 32'h0000_0200);
    next_cycle();                                // last strobe lands
    read_check(`HK_REG_IDLY, {19'b0, 5'd31, 3'b0, 5'd17});
    delay_a = 1'b1;                              // both taps now >= 16
    delay_b = 1'b1;
    repeat (4) next_cycle();
    adc_chk_en = 1'b1;
    wait_samples(10);

    // snapshot vs ports at the last valid before the request
    for (int r = 0; r < 4; r++)
    begin
      repeat (r) next_cycle();                   // vary the beat phase
      read_check(`HK_REG_ADC, {16'($signed(last_b)), 16'($signed(last_a))});
    end

    if (adc_checks >= 20)
    begin
      $display("Simulation passed");
      $finish;
    end
    else
      fail_run("too few ADC samples were checked");
  end

endmodule

/* rp_top.sv */
// top level: plain bus and pin ports onto the bus and
// delay control interfaces, ADC capture and register block

`timescale 1ns/100ps

`include "hk_consts.svh"

module rp_top (
  input  logic                 adc_clk2d,
  input  logic                 reset_i,
  // ADC ddr lanes
  input  logic [`HK_LANES-1:0] adc_lanes_a_i,
  input  logic [`HK_LANES-1:0] adc_lanes_b_i,
  // system bus
  input  logic [`HK_BUS_AW-1:0] sys_addr_i,
  input  logic [`HK_BUS_DW-1:0] sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output logic [`HK_BUS_DW-1:0] sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  // expansion connector
  input  logic [`HK_EXP_W-1:0] exp_p_dat_i,
  input  logic [`HK_EXP_W-1:0] exp_n_dat_i,
  output logic [`HK_EXP_W-1:0] exp_p_dat_o,
  output logic [`HK_EXP_W-1:0] exp_n_dat_o,
  output logic [`HK_EXP_W-1:0] exp_p_dir_o,
  output logic [`HK_EXP_W-1:0] exp_n_dir_o,
  output logic [`HK_LED_W-1:0] led_o,
  // converted samples
  output logic [`HK_ADC_W-1:0] adc_dat_a_o,
  output logic [`HK_ADC_W-1:0] adc_dat_b_o,
  output logic                 adc_valid_o
);

  sys_bus_if bus ();
  idly_if    idly ();

  assign bus.addr    = sys_addr_i;     // master side from the ports
  assign bus.wdata   = sys_wdata_i;
  assign bus.wen     = sys_wen_i;
  assign bus.ren     = sys_ren_i;
  assign sys_rdata_o = bus.rdata;
  assign sys_ack_o   = bus.ack;
  assign sys_err_o   = bus.err;

  adc_capture u_adc_capture (
    .adc_clk2d (adc_clk2d    ),
    .reset_i   (reset_i      ),
    .lanes_a_i (adc_lanes_a_i),
    .lanes_b_i (adc_lanes_b_i),
    .tap       (idly         ),
    .dat_a_o   (adc_dat_a_o  ),
    .dat_b_o   (adc_dat_b_o  ),
    .valid_o   (adc_valid_o  )
  );

  hk_regs u_hk_regs (
    .adc_clk2d   (adc_clk2d  ),
    .reset_i     (reset_i    ),
    .bus         (bus        ),
    .idly        (idly       ),
    .exp_p_dat_i (exp_p_dat_i),
    .exp_n_dat_i (exp_n_dat_i),
    .exp_p_dat_o (exp_p_dat_o),
    .exp_n_dat_o (exp_n_dat_o),
    .exp_p_dir_o (exp_p_dir_o),
    .exp_n_dir_o (exp_n_dir_o),
    .led_o       (led_o      ),
    .adc_a_i     (adc_dat_a_o),   // snapshot taps the output ports
    .adc_b_i     (adc_dat_b_o),
    .adc_valid_i (adc_valid_o)
  );

endmodule

/* hk_regs.sv */
// housekeeping register block on the system bus
// ID, LED, expansion connector direction/output/input,
// delay tap strobes and readback, ADC sample snapshot

`timescale 1ns/100ps

`include "hk_consts.svh"

module hk_regs (
  input  logic                        adc_clk2d,
  input  logic                        reset_i,
  sys_bus_if.slave                    bus,
  idly_if.ctl                         idly,
  input  logic [`HK_EXP_W-1:0]        exp_p_dat_i,  // pin inputs
  input  logic [`HK_EXP_W-1:0]        exp_n_dat_i,
  output logic [`HK_EXP_W-1:0]        exp_p_dat_o,  // pin outputs
  output logic [`HK_EXP_W-1:0]        exp_n_dat_o,
  output logic [`HK_EXP_W-1:0]        exp_p_dir_o,  // 1 = drive pin
  output logic [`HK_EXP_W-1:0]        exp_n_dir_o,
  output logic [`HK_LED_W-1:0]        led_o,
  input  logic signed [`HK_ADC_W-1:0] adc_a_i,
  input  logic signed [`HK_ADC_W-1:0] adc_b_i,
  input  logic                        adc_valid_i
);

  import hk_pkg::*;

  logic                  req;        // any access this cycle
  logic                  hit;        // address is a known register
  logic                  idly_wr;
  logic [`HK_BUS_DW-1:0] rd_mux;
  logic [`HK_EXP_W-1:0]  exp_p_in;   // registered pin inputs
  logic [`HK_EXP_W-1:0]  exp_n_in;
  adc_word_u             snap_a;     // last valid sample pair
  adc_word_u             snap_b;

  assign req     = bus.wen | bus.ren;
  assign idly_wr = bus.wen & (bus.addr == `HK_REG_IDLY);

  //////////////////////////////////////////////////
  // bus handshake
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk2d)
  begin
    if (reset_i)
    begin
      bus.ack <= 1'b0;
      bus.err <= 1'b0;
    end
    else
    begin
      bus.ack <= req;               // always one cycle after request
      bus.err <= req & ~hit;
    end
  end

  always_ff @(posedge adc_clk2d)
  begin
    bus.rdata <= bus.ren ? rd_mux : '0;
  end

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk2d)
  begin
    if (reset_i)
    begin
      exp_p_dir_o <= '0;
      exp_n_dir_o <= '0;
      exp_p_dat_o <= '0;
      exp_n_dat_o <= '0;
      led_o       <= '0;
    end
    else if (bus.wen)
    begin
      case (bus.addr)
        `HK_REG_EXP_P_DIR: exp_p_dir_o <= bus.wdata[`HK_EXP_W-1:0];
        `HK_REG_EXP_N_DIR: exp_n_dir_o <= bus.wdata[`HK_EXP_W-1:0];
        `HK_REG_EXP_P_OUT: exp_p_dat_o <= bus.wdata[`HK_EXP_W-1:0];
        `HK_REG_EXP_N_OUT: exp_n_dat_o <= bus.wdata[`HK_EXP_W-1:0];
        `HK_REG_LED:       led_o       <= bus.wdata[`HK_LED_W-1:0];
        default:           ;            // read-only or unknown, ack only
      endcase
    end
  end

  // tap strobes, single cycle, same edge as ack
  always_ff @(posedge adc_clk2d)
  begin
    if (reset_i)
    begin
      idly.ld  <= '0;
      idly.ce  <= '0;
      idly.inc <= '0;
    end
    else if (idly_wr)
    begin
      idly.ld  <= {bus.wdata[`HK_IDLY_CH_B+0], bus.wdata[0]};
      idly.ce  <= {bus.wdata[`HK_IDLY_CH_B+1], bus.wdata[1]};
      idly.inc <= {bus.wdata[`HK_IDLY_CH_B+2], bus.wdata[2]};
    end
    else
    begin
      idly.ld  <= '0;
      idly.ce  <= '0;
      idly.inc <= '0;
    end
  end

  //////////////////////////////////////////////////
  // input capture and read mux
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk2d)
  begin
    exp_p_in <= exp_p_dat_i;
    exp_n_in <= exp_n_dat_i;
    if (adc_valid_i)
    begin
      snap_a.code <= adc_a_i;
      snap_b.code <= adc_b_i;
    end
  end

  always_comb
  begin
    hit    = 1'b1;
    rd_mux = '0;
    case (bus.addr)
      `HK_REG_ID:        rd_mux = `HK_ID_VAL;
      `HK_REG_EXP_P_DIR: rd_mux[`HK_EXP_W-1:0] = exp_p_dir_o;
      `HK_REG_EXP_N_DIR: rd_mux[`HK_EXP_W-1:0] = exp_n_dir_o;
      `HK_REG_EXP_P_OUT: rd_mux[`HK_EXP_W-1:0] = exp_p_dat_o;
      `HK_REG_EXP_N_OUT: rd_mux[`HK_EXP_W-1:0] = exp_n_dat_o;
      `HK_REG_EXP_P_IN:  rd_mux[`HK_EXP_W-1:0] = exp_p_in;
      `HK_REG_EXP_N_IN:  rd_mux[`HK_EXP_W-1:0] = exp_n_in;
      `HK_REG_LED:       rd_mux[`HK_LED_W-1:0] = led_o;
      `HK_REG_IDLY:
      begin
        rd_mux[`HK_TAP_W-1:0]              = idly.cnt[0];   // tap A
        rd_mux[`HK_IDLY_CH_B +: `HK_TAP_W] = idly.cnt[1];   // tap B
      end
      `HK_REG_ADC:                          // B high half, A low half
        rd_mux = {{(`HK_BUS_DW/2-`HK_ADC_W){snap_b.code[`HK_ADC_W-1]}}, snap_b.code,
                  {(`HK_BUS_DW/2-`HK_ADC_W){snap_a.code[`HK_ADC_W-1]}}, snap_a.code};
      default:           hit = 1'b0;
    endcase
  end

endmodule

/* adc_capture.sv */
// ADC input path for two channels
// beat pairing of the ddr lanes, delay tap counters,
// one beat lane delay above half tap range, code conversion

`timescale 1ns/100ps

`include "hk_consts.svh"

module adc_capture (
  input  logic                        adc_clk2d,
  input  logic                        reset_i,
  input  logic [`HK_LANES-1:0]        lanes_a_i,   // channel A lanes
  input  logic [`HK_LANES-1:0]        lanes_b_i,   // channel B lanes
  idly_if.tap                         tap,
  output logic signed [`HK_ADC_W-1:0] dat_a_o,     // two's complement
  output logic signed [`HK_ADC_W-1:0] dat_b_o,
  output logic                        valid_o      // every 2nd cycle
);

  import hk_pkg::*;

  logic [1:0][`HK_LANES-1:0] lanes_in;   // [0] A, [1] B
  logic [1:0][`HK_ADC_W-1:0] dat;
  logic                      phase_b;    // 0: beat A edge, 1: beat B edge
  logic                      pair_done;  // both beats in the word

  assign lanes_in = {lanes_b_i, lanes_a_i};
  assign dat_a_o  = dat[0];
  assign dat_b_o  = dat[1];

  //////////////////////////////////////////////////
  // beat phase and output strobe
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk2d)
  begin
    if (reset_i)
    begin
      phase_b   <= 1'b0;            // start on beat A
      pair_done <= 1'b0;
      valid_o   <= 1'b0;
    end
    else
    begin
      phase_b   <= ~phase_b;
      pair_done <= phase_b;         // B beat just taken
      valid_o   <= pair_done;       // aligned with dat update
    end
  end

  //////////////////////////////////////////////////
  // per channel datapath
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < 2; ch++)
  begin : g_ch
    logic [`HK_TAP_W-1:0] tap_cnt;
    logic [`HK_LANES-1:0] lanes_d;     // lanes one beat late
    logic [`HK_LANES-1:0] lanes_sel;
    adc_word_u            word;

    // tap counter, wraps both ways
    always_ff @(posedge adc_clk2d)
    begin
      if (reset_i)
        tap_cnt <= '0;
      else if (tap.ld[ch])
        tap_cnt <= '0;
      else if (tap.ce[ch])
        tap_cnt <= tap.inc[ch] ? tap_cnt + 1'b1 : tap_cnt - 1'b1;
    end

    assign tap.cnt[ch] = tap_cnt;

    always_ff @(posedge adc_clk2d)
    begin
      lanes_d <= lanes_in[ch];
    end

    // upper half of tap range shifts capture by one beat
    assign lanes_sel = (tap_cnt >= `HK_TAP_HALF) ? lanes_d : lanes_in[ch];

    // beat A to even bits, beat B to odd bits
    always_ff @(posedge adc_clk2d)
    begin
      for (int k = 0; k < `HK_LANES; k++)
      begin
        if (!phase_b)
          word.lane[k].beat_a <= lanes_sel[k];
        else
          word.lane[k].beat_b <= lanes_sel[k];
      end
    end

    // unsigned negative slope to two's complement
    always_ff @(posedge adc_clk2d)
    begin
      if (reset_i)
        dat[ch] <= '0;
      else if (pair_done)
        dat[ch] <= {word.code[`HK_ADC_W-1], ~word.code[`HK_ADC_W-2:0]};
    end
  end

endmodule

/* hk_pkg.sv */
// shared types: captured ADC word seen as lane pairs or as one code

`include "hk_consts.svh"

package hk_pkg;

  // one lane, two beats; beat_a lands on the even bit
  typedef struct packed {
    logic beat_b;                               // odd bit
    logic beat_a;                               // even bit
  } lane_bits_t;

  typedef union packed {
    lane_bits_t [`HK_LANES-1:0] lane;           // lane k -> bits 2k+1:2k
    logic       [`HK_ADC_W-1:0] code;           // raw converter code
  } adc_word_u;

endpackage

/* idly_if.sv */
// input delay control, register block to ADC capture
// strobes one bit per channel, tap counts back

`timescale 1ns/100ps

`include "hk_consts.svh"

interface idly_if;

  logic [1:0]                ld;     // clear tap
  logic [1:0]                ce;     // step tap
  logic [1:0]                inc;    // step direction, 1 = up
  logic [1:0][`HK_TAP_W-1:0] cnt;    // [0] channel A, [1] channel B

  modport ctl (
    output ld, ce, inc,
    input  cnt
  );

  modport tap (
    input  ld, ce, inc,
    output cnt
  );

endinterface

/* sys_bus_if.sv */
// system bus between top level and register block
// request pulse, ack one cycle later

`timescale 1ns/100ps

`include "hk_consts.svh"

interface sys_bus_if;

  logic [`HK_BUS_AW-1:0] addr;    // byte address
  logic [`HK_BUS_DW-1:0] wdata;
  logic                  wen;     // single cycle write pulse
  logic                  ren;     // single cycle read pulse
  logic [`HK_BUS_DW-1:0] rdata;   // valid with ack on reads
  logic                  ack;
  logic                  err;     // unknown address, pulses with ack

  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

/* hk_consts.svh */
// widths of bus, ADC lanes, expansion pins and LEDs
// register byte offsets of the housekeeping block
// ID word and delay tap constants

`ifndef HK_CONSTS_SVH
`define HK_CONSTS_SVH

`define HK_LANES          7            // ddr lanes per channel
`define HK_ADC_W          14           // sample width
`define HK_BUS_AW         20           // system bus address
`define HK_BUS_DW         32           // system bus data
`define HK_EXP_W          9            // expansion pins per side
`define HK_LED_W          8
`define HK_TAP_W          5
`define HK_TAP_HALF       5'd16        // lane delay kicks in here
`define HK_IDLY_CH_B      8            // channel B field in IDLY reg
`define HK_ID_VAL         32'h5250_0001

// register offsets, full address width
`define HK_REG_ID         20'h00
`define HK_REG_EXP_P_DIR  20'h10
`define HK_REG_EXP_N_DIR  20'h14
`define HK_REG_EXP_P_OUT  20'h18
`define HK_REG_EXP_N_OUT  20'h1C
`define HK_REG_EXP_P_IN   20'h20
`define HK_REG_EXP_N_IN   20'h24
`define HK_REG_LED        20'h30
`define HK_REG_IDLY       20'h34
`define HK_REG_ADC        20'h40

`endif
